// File: hw/poly_mm_macros.svh
`ifndef POLY_MM_MACROS_SVH
`define POLY_MM_MACROS_SVH

// operand, modulus and result width
`define PMM_DATA_W 24

// windows, residues and the barrett constant carry one guard bit
`define PMM_WIDE_W 25

// bit-length code width
`define PMM_N_W 5

// largest modulus bit length the windows can hold
`define PMM_N_MAX 24

// enable to valid, in clock cycles
`define PMM_LATENCY 4

`endif

// File: hw/poly_mm_pkg.sv
`default_nettype none

`include "poly_mm_macros.svh"

package poly_mm_pkg;

    // a, b, q and the reduced result
    typedef logic [`PMM_DATA_W-1:0] data_t;

    // seed, quotient, low residue and m
    // one bit wider than data_t so R can reach 2q
    typedef logic [`PMM_WIDE_W-1:0] wide_t;

    // modulus bit length N, legal range 1 to PMM_N_MAX
    typedef logic [`PMM_N_W-1:0] nbits_t;

endpackage

`default_nettype wire

// File: hw/product_stage.sv
`timescale 1ns/10ps
`default_nettype none

`include "poly_mm_macros.svh"

module product_stage (
    input  logic                 poly_mm_clk,
    input  logic                 poly_mm_rst_n,
    input  logic                 enable,
    input  poly_mm_pkg::data_t   a,
    input  poly_mm_pkg::data_t   b,
    input  poly_mm_pkg::nbits_t  n,
    output poly_mm_pkg::wide_t   seed,
    output logic                 seed_valid,
    output poly_mm_pkg::wide_t   low_residue
);

    // full operand product
    logic [2*`PMM_DATA_W-1:0] prod;
    // product after the N-1 right shift
    logic [2*`PMM_DATA_W-1:0] prod_shr;
    poly_mm_pkg::wide_t       seed_win;
    // N+1 low-bit mask
    poly_mm_pkg::wide_t       low_mask;
    poly_mm_pkg::wide_t       low_win;
    // low residue delay line, stage 3 reads the last tap
    poly_mm_pkg::wide_t       low_pipe [3];

    assign prod = a * b;

    // P0 >> (N-1), top bits beyond the window are dropped
    assign prod_shr = prod >> (n - 5'd1);
    assign seed_win = prod_shr[`PMM_WIDE_W-1:0];

    // ones below bit N+1
    // N = 24 shifts everything out and keeps the full word
    assign low_mask = ~({`PMM_WIDE_W{1'b1}} << (n + 5'd1));
    assign low_win  = prod[`PMM_WIDE_W-1:0] & low_mask;

    // seed register feeds the quotient stage
    always_ff @(posedge poly_mm_clk) begin
        seed <= seed_win;
    end

    // stage valid follows enable one cycle late
    always_ff @(posedge poly_mm_clk or negedge poly_mm_rst_n) begin
        if (!poly_mm_rst_n) begin
            seed_valid <= 1'b0;
        end else begin
            seed_valid <= enable;
        end
    end

    // three taps so the residue meets q*quotient in stage 3
    always_ff @(posedge poly_mm_clk) begin
        low_pipe[0] <= low_win;
        low_pipe[1] <= low_pipe[0];
        low_pipe[2] <= low_pipe[1];
    end

    assign low_residue = low_pipe[2];

    // shift windows only cover N in 1..PMM_N_MAX
    // out of range N corrupts every later stage
    a_n_in_range : assert property (
        @(posedge poly_mm_clk) disable iff (!poly_mm_rst_n)
        enable |-> (n >= 5'd1 && n <= 5'(`PMM_N_MAX))
    ) else $error("product_stage: bit length n=%0d out of range", n);

endmodule

`default_nettype wire

// File: hw/quotient_stage.sv
`timescale 1ns/10ps
`default_nettype none

`include "poly_mm_macros.svh"

module quotient_stage (
    input  logic                 poly_mm_clk,
    input  logic                 poly_mm_rst_n,
    input  poly_mm_pkg::wide_t   seed,
    input  logic                 seed_valid,
    input  poly_mm_pkg::wide_t   m,
    input  poly_mm_pkg::nbits_t  n,
    output poly_mm_pkg::wide_t   quotient,
    output logic                 quotient_valid
);

    // seed times barrett constant
    logic [2*`PMM_WIDE_W-1:0] quo_prod;
    // product after the N+1 right shift
    logic [2*`PMM_WIDE_W-1:0] quo_shr;
    poly_mm_pkg::wide_t       quo_win;

    assign quo_prod = seed * m;

    // estimate of floor(a*b / q)
    // can undershoot slightly and stage 4 corrects it
    assign quo_shr = quo_prod >> (n + 5'd1);
    assign quo_win = quo_shr[`PMM_WIDE_W-1:0];

    // quotient word register
    always_ff @(posedge poly_mm_clk) begin
        quotient <= quo_win;
    end

    // valid moves with the quotient
    always_ff @(posedge poly_mm_clk or negedge poly_mm_rst_n) begin
        if (!poly_mm_rst_n) begin
            quotient_valid <= 1'b0;
        end else begin
            quotient_valid <= seed_valid;
        end
    end

endmodule

`default_nettype wire

// File: hw/reduce_stage.sv
`timescale 1ns/10ps
`default_nettype none

`include "poly_mm_macros.svh"

module reduce_stage (
    input  logic                 poly_mm_clk,
    input  logic                 poly_mm_rst_n,
    input  poly_mm_pkg::wide_t   quotient,
    input  logic                 quotient_valid,
    input  poly_mm_pkg::wide_t   low_residue,
    input  poly_mm_pkg::data_t   q,
    input  poly_mm_pkg::nbits_t  n,
    output poly_mm_pkg::data_t   result,
    output logic                 valid
);

    // quotient times modulus
    logic [`PMM_WIDE_W+`PMM_DATA_W-1:0] qq_prod;
    // N+1 low-bit mask, shared by both subtractions
    poly_mm_pkg::wide_t red_mask;
    poly_mm_pkg::wide_t term_win;
    // stage 3 registers
    poly_mm_pkg::wide_t term_reg;
    logic               term_valid;
    // stage 4 combinational path
    poly_mm_pkg::wide_t r_diff;
    poly_mm_pkg::wide_t r_masked;
    poly_mm_pkg::wide_t q_wide;
    poly_mm_pkg::wide_t r_sub;
    poly_mm_pkg::data_t result_next;

    assign red_mask = ~({`PMM_WIDE_W{1'b1}} << (n + 5'd1));

    // only the low N+1 bits of t are ever needed
    assign qq_prod  = quotient * q;
    assign term_win = qq_prod[`PMM_WIDE_W-1:0] & red_mask;

    // stage 3 term register
    always_ff @(posedge poly_mm_clk) begin
        term_reg <= term_win;
    end

    always_ff @(posedge poly_mm_clk or negedge poly_mm_rst_n) begin
        if (!poly_mm_rst_n) begin
            term_valid <= 1'b0;
        end else begin
            term_valid <= quotient_valid;
        end
    end

    // R = (low - t) mod 2^(N+1)
    // wraparound in the 25-bit subtract is removed by the mask
    assign r_diff   = low_residue - term_reg;
    assign r_masked = r_diff & red_mask;

    // one conditional correction
    // enough when the quotient estimate is off by at most one
    assign q_wide      = {1'b0, q};
    assign r_sub       = r_masked - q_wide;
    assign result_next = (r_masked < q_wide) ? r_masked[`PMM_DATA_W-1:0]
                                             : r_sub[`PMM_DATA_W-1:0];

    // result register
    // loads every cycle, meaningful only with valid
    always_ff @(posedge poly_mm_clk or negedge poly_mm_rst_n) begin
        if (!poly_mm_rst_n) begin
            result <= '0;
        end else begin
            result <= result_next;
        end
    end

    always_ff @(posedge poly_mm_clk or negedge poly_mm_rst_n) begin
        if (!poly_mm_rst_n) begin
            valid <= 1'b0;
        end else begin
            valid <= term_valid;
        end
    end

    // valid chain is reset all the way from the product stage
    a_valid_known : assert property (
        @(posedge poly_mm_clk) disable iff (!poly_mm_rst_n)
        !$isunknown(valid)
    ) else $error("reduce_stage: valid is unknown");

    // a delivered result never exceeds the N+1 bit window
    // requires n held steady while operations are in flight
    a_result_in_window : assert property (
        @(posedge poly_mm_clk) disable iff (!poly_mm_rst_n)
        valid |-> (({1'b0, result} & ~red_mask) == '0)
    ) else $error("reduce_stage: result 0x%06h wider than n+1=%0d bits", result, n + 5'd1);

endmodule

`default_nettype wire

// File: hw/barrett_mm_top.sv
`timescale 1ns/10ps
`default_nettype none

module barrett_mm_top (
    input  logic                 poly_mm_clk,
    input  logic                 poly_mm_rst_n,
    input  logic                 enable,
    input  poly_mm_pkg::data_t   a,
    input  poly_mm_pkg::data_t   b,
    input  poly_mm_pkg::wide_t   m,
    input  poly_mm_pkg::nbits_t  n,
    input  poly_mm_pkg::data_t   q,
    output logic                 valid,
    output poly_mm_pkg::data_t   result
);

    // stage 1 to stage 2
    poly_mm_pkg::wide_t seed;
    logic               seed_valid;
    // stage 1 to stage 3, already delayed to line up with t
    poly_mm_pkg::wide_t low_residue;
    // stage 2 to stage 3
    poly_mm_pkg::wide_t quotient;
    logic               quotient_valid;

    // a*b, seed window and low residue
    product_stage u_product_stage (
        .poly_mm_clk   (poly_mm_clk),
        .poly_mm_rst_n (poly_mm_rst_n),
        .enable        (enable),
        .a             (a),
        .b             (b),
        .n             (n),
        .seed          (seed),
        .seed_valid    (seed_valid),
        .low_residue   (low_residue)
    );

    // seed*m and quotient window
    // m and n are not pipelined, held by the caller
    quotient_stage u_quotient_stage (
        .poly_mm_clk    (poly_mm_clk),
        .poly_mm_rst_n  (poly_mm_rst_n),
        .seed           (seed),
        .seed_valid     (seed_valid),
        .m              (m),
        .n              (n),
        .quotient       (quotient),
        .quotient_valid (quotient_valid)
    );

    // quotient*q, subtract, mask, correct, register
    reduce_stage u_reduce_stage (
        .poly_mm_clk    (poly_mm_clk),
        .poly_mm_rst_n  (poly_mm_rst_n),
        .quotient       (quotient),
        .quotient_valid (quotient_valid),
        .low_residue    (low_residue),
        .q              (q),
        .n              (n),
        .result         (result),
        .valid          (valid)
    );

endmodule

`default_nettype wire

// File: verif/tb_barrett_mm.sv
`timescale 1ns/10ps
`default_nettype none

`include "poly_mm_macros.svh"

module tb_barrett_mm;

    // test sizes, watchdog budget follows from them
    localparam int NUM_TESTS       = 5;
    localparam int RESET_CYCLES    = 8;
    localparam int LAT_PAIRS       = 6;
    localparam int BURST_OPS       = 32;
    localparam int WIDTH_OPS       = 24;
    localparam int GAP_OPS         = 16;
    localparam int TOTAL_OPS       = LAT_PAIRS + BURST_OPS + 2 * WIDTH_OPS + GAP_OPS;
    localparam int WATCHDOG_CYCLES = TOTAL_OPS + 8 * NUM_TESTS + 50;

    // moduli and their bit lengths
    localparam int Q_12 = 3329;
    localparam int Q_23 = 8380417;
    localparam int Q_5  = 29;

    logic                poly_mm_clk = 1'b0;
    logic                poly_mm_rst_n;
    logic                enable;
    poly_mm_pkg::data_t  a;
    poly_mm_pkg::data_t  b;
    poly_mm_pkg::wide_t  m;
    poly_mm_pkg::nbits_t n;
    poly_mm_pkg::data_t  q;
    logic                valid;
    poly_mm_pkg::data_t  result;

    // scoreboard, one entry per issued operation, oldest first
    poly_mm_pkg::data_t exp_result_q [$];
    poly_mm_pkg::data_t exp_direct_q [$];
    bit                 direct_ok_q [$];
    longint             issue_cycle_q [$];

    // monitor scratch
    poly_mm_pkg::data_t mon_exp;
    poly_mm_pkg::data_t mon_direct;
    bit                 mon_direct_ok;
    longint             mon_issued;

    integer rand_seed;
    longint cycle_count  = 0;
    int     error_count  = 0;
    int     valid_count  = 0;
    int     tests_failed = 0;

    barrett_mm_top dut (
        .poly_mm_clk   (poly_mm_clk),
        .poly_mm_rst_n (poly_mm_rst_n),
        .enable        (enable),
        .a             (a),
        .b             (b),
        .m             (m),
        .n             (n),
        .q             (q),
        .valid         (valid),
        .result        (result)
    );

    // 10 ns clock
    always #5 poly_mm_clk = ~poly_mm_clk;

    always @(posedge poly_mm_clk) begin
        cycle_count <= cycle_count + 1;
    end

    // barrett steps 1..6, returns R before the correction
    function automatic logic [63:0] model_r(input logic [63:0] av, input logic [63:0] bv,
                                            input logic [63:0] mv, input logic [63:0] qv,
                                            input int nv);
        logic [63:0] wide_mask;
        logic [63:0] win_mask;
        logic [63:0] p0;
        logic [63:0] seed_w;
        logic [63:0] quo_w;
        logic [63:0] t;
        wide_mask = (64'd1 << `PMM_WIDE_W) - 64'd1;
        win_mask  = (64'd1 << (nv + 1)) - 64'd1;
        p0        = av * bv;
        // seed and quotient windows are 25 bits
        seed_w    = (p0 >> (nv - 1)) & wide_mask;
        quo_w     = ((seed_w * mv) >> (nv + 1)) & wide_mask;
        t         = (quo_w * qv) & win_mask;
        return ((p0 & win_mask) - t) & win_mask;
    endfunction

    // step 7, single subtraction of q
    function automatic poly_mm_pkg::data_t model_result(input logic [63:0] r,
                                                        input logic [63:0] qv);
        logic [63:0] corrected;
        if (r < qv) begin
            corrected = r;
        end else begin
            corrected = r - qv;
        end
        return corrected[`PMM_DATA_W-1:0];
    endfunction

    function automatic poly_mm_pkg::data_t rand_below(input poly_mm_pkg::data_t limit);
        logic [31:0] raw;
        raw = $random(rand_seed);
        return poly_mm_pkg::data_t'(raw % limit);
    endfunction

    task automatic report_mismatch(input string sig, input logic [63:0] expv,
                                   input logic [63:0] gotv);
        $display("[ERROR] %s: expected 0x%0h, got 0x%0h", sig, expv, gotv);
        error_count++;
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (error_count != errs_before) begin
            tests_failed++;
            $display("test %s: failed, %0d errors", name, error_count - errs_before);
        end else begin
            $display("test %s: ok", name);
        end
    endtask

    // new modulus, only with nothing in flight
    task automatic set_modulus(input int qv, input int nv);
        logic [63:0] mv;
        @(negedge poly_mm_clk);
        mv = (64'd1 << (2 * nv)) / 64'(qv);
        q  = poly_mm_pkg::data_t'(qv);
        n  = poly_mm_pkg::nbits_t'(nv);
        m  = mv[`PMM_WIDE_W-1:0];
    endtask

    task automatic issue_op(input poly_mm_pkg::data_t av, input poly_mm_pkg::data_t bv);
        logic [63:0] r;
        logic [63:0] direct;
        @(negedge poly_mm_clk);
        enable = 1'b1;
        a      = av;
        b      = bv;
        r      = model_r(64'(av), 64'(bv), 64'(m), 64'(q), int'(n));
        direct = (64'(av) * 64'(bv)) % 64'(q);
        exp_result_q.push_back(model_result(r, 64'(q)));
        exp_direct_q.push_back(direct[`PMM_DATA_W-1:0]);
        // one correction only reaches a*b mod q below 2q
        direct_ok_q.push_back(r < 2 * 64'(q));
        issue_cycle_q.push_back(cycle_count);
    endtask

    task automatic idle_cycle();
        @(negedge poly_mm_clk);
        enable = 1'b0;
    endtask

    // wait for the scoreboard to empty
    task automatic drain_ops();
        int waited;
        waited = 0;
        do begin
            @(posedge poly_mm_clk);
            waited++;
        end while (exp_result_q.size() != 0 && waited < 4 * `PMM_LATENCY);
        if (exp_result_q.size() != 0) begin
            $display("%0d operations still pending, valid never came back",
                     exp_result_q.size());
            error_count++;
            exp_result_q.delete();
            exp_direct_q.delete();
            direct_ok_q.delete();
            issue_cycle_q.delete();
        end
    endtask

    // compare every valid result in order
    always @(negedge poly_mm_clk) begin
        if (poly_mm_rst_n === 1'b1 && valid === 1'b1) begin
            valid_count++;
            if (exp_result_q.size() == 0) begin
                $display("valid high at cycle %0d with no operation in flight", cycle_count);
                error_count++;
            end else begin
                mon_exp       = exp_result_q.pop_front();
                mon_direct    = exp_direct_q.pop_front();
                mon_direct_ok = direct_ok_q.pop_front();
                mon_issued    = issue_cycle_q.pop_front();
                if (cycle_count - mon_issued != `PMM_LATENCY) begin
                    report_mismatch("valid latency", `PMM_LATENCY, cycle_count - mon_issued);
                end
                if (result !== mon_exp) begin
                    report_mismatch("result", mon_exp, result);
                end
                if (mon_direct_ok && result !== mon_direct) begin
                    report_mismatch("result (a*b mod q)", mon_direct, result);
                end
            end
        end
    end

    // single enable, valid counted from the issue edge
    task automatic check_single_op(input poly_mm_pkg::data_t av, input poly_mm_pkg::data_t bv);
        int          waited;
        logic [63:0] direct;
        waited = 0;
        direct = (64'(av) * 64'(bv)) % 64'(q);
        issue_op(av, bv);
        do begin
            @(negedge poly_mm_clk);
            enable = 1'b0;
            waited++;
        end while (valid !== 1'b1 && waited < 4 * `PMM_LATENCY);
        if (valid !== 1'b1) begin
            $display("no valid within %0d cycles for a=0x%0h b=0x%0h", waited, av, bv);
            error_count++;
        end else begin
            if (waited != `PMM_LATENCY) begin
                report_mismatch("valid latency", `PMM_LATENCY, waited);
            end
            if (result !== direct[`PMM_DATA_W-1:0]) begin
                report_mismatch("result", direct, result);
            end
        end
    endtask

    task automatic test_reset_state();
        int errs_before;
        errs_before = error_count;
        poly_mm_rst_n = 1'b0;
        repeat (RESET_CYCLES) begin
            @(negedge poly_mm_clk);
            if (valid !== 1'b0) report_mismatch("valid", 0, valid);
            if (result !== '0) report_mismatch("result", 0, result);
        end
        poly_mm_rst_n = 1'b1;
        // still idle just after release
        repeat (2) begin
            @(negedge poly_mm_clk);
            if (valid !== 1'b0) report_mismatch("valid", 0, valid);
            if (result !== '0) report_mismatch("result", 0, result);
        end
        report_test("reset_state", errs_before);
    endtask

    task automatic test_latency();
        int errs_before;
        errs_before = error_count;
        // includes 0 and q-1 corners
        check_single_op(24'd0, 24'd3328);
        check_single_op(24'd3328, 24'd3328);
        check_single_op(24'd1, 24'd1);
        check_single_op(24'd17, 24'd3328);
        check_single_op(24'd1234, 24'd2345);
        check_single_op(24'd2000, 24'd3000);
        drain_ops();
        report_test("latency", errs_before);
    endtask

    // random operands below q, one per cycle
    task automatic run_random_burst(input int count);
        for (int i = 0; i < count; i++) begin
            issue_op(rand_below(q), rand_below(q));
        end
        idle_cycle();
        drain_ops();
    endtask

    task automatic test_back_to_back();
        int errs_before;
        int valids_before;
        errs_before   = error_count;
        valids_before = valid_count;
        run_random_burst(BURST_OPS);
        if (valid_count - valids_before != BURST_OPS) begin
            report_mismatch("valid count", BURST_OPS, valid_count - valids_before);
        end
        report_test("back_to_back", errs_before);
    endtask

    task automatic test_other_bit_lengths();
        int errs_before;
        errs_before = error_count;
        set_modulus(Q_23, 23);
        run_random_burst(WIDTH_OPS);
        set_modulus(Q_5, 5);
        run_random_burst(WIDTH_OPS);
        report_test("other_bit_lengths", errs_before);
    endtask

    task automatic test_operation_gaps();
        int          errs_before;
        int          valids_before;
        logic [31:0] gap;
        errs_before   = error_count;
        valids_before = valid_count;
        set_modulus(Q_12, 12);
        for (int i = 0; i < GAP_OPS; i++) begin
            issue_op(rand_below(q), rand_below(q));
            gap = $random(rand_seed);
            // 0 to 2 idle cycles after each enable
            repeat (gap % 3) idle_cycle();
        end
        idle_cycle();
        drain_ops();
        if (valid_count - valids_before != GAP_OPS) begin
            report_mismatch("valid count", GAP_OPS, valid_count - valids_before);
        end
        report_test("operation_gaps", errs_before);
    endtask

    initial begin
        rand_seed     = 32'hed48_0132;
        poly_mm_rst_n = 1'b0;
        enable        = 1'b0;
        a             = '0;
        b             = '0;
        q             = 24'd3329;
        n             = 5'd12;
        // floor(2^24 / 3329)
        m             = 25'd5039;

        test_reset_state();
        test_latency();
        test_back_to_back();
        test_other_bit_lengths();
        test_operation_gaps();

        $display("tests run %0d, tests failed %0d, errors %0d",
                 NUM_TESTS, tests_failed, error_count);
        if (error_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // bound on the whole run
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge poly_mm_clk);
        $display("watchdog expired after %0d cycles, run did not finish", WATCHDOG_CYCLES);
        $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
+incdir+hw
hw/poly_mm_pkg.sv
hw/product_stage.sv
hw/quotient_stage.sv
hw/reduce_stage.sv
hw/barrett_mm_top.sv
verif/tb_barrett_mm.sv

// File: run_sim.sh
#!/bin/sh
# build and run the barrett multiplier testbench with verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --assert -Wno-fatal \
    -f compile.f \
    --top-module tb_barrett_mm \
    -Mdir obj_dir -o tb_barrett_mm > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status, see $BUILD_LOG"
    exit 1
fi

./obj_dir/tb_barrett_mm > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TB FAILED" "$SIM_LOG"; then
    exit 1
fi
exit 0
